//--- soc_top.f
axi_pkg.sv
mem_pkg.sv
axi_if.sv
axi_router.sv
burst_counter.sv
sram_array.sv
slave_fsm.sv
soc_top.sv
tb_clock_gen.sv
soc_top_asserts.sv
tb_soc_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_soc_top
FILELIST  = soc_top.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- soc_tests.txt
# op id addr len burst strb stall data..., all hex; len is beats minus 1, burst 0 FIXED 1 INCR
# W data are written words; R data are expected words and strb is unused; stall holds bready/rready low
W 1 00000010 0 1 f 0 deadbeef
R 2 00000010 0 1 f 0 deadbeef
# same word offset in IM and DM
W 3 00000040 0 1 f 0 11112222
W 4 00010040 0 1 f 0 33334444
R 5 00000040 0 1 f 0 11112222
R 6 00010040 0 1 f 0 33334444
# 4-beat INCR in DM
W 7 00010100 3 1 f 0 a0000001 a0000002 a0000003 a0000004
R 8 00010100 3 1 f 0 a0000001 a0000002 a0000003 a0000004
# FIXED 3 beats, only the last stays
W 9 00000200 2 0 f 0 c0c0c0c0 c1c1c1c1 c2c2c2c2
R a 00000200 0 1 f 0 c2c2c2c2
# low two bytes only
W b 00000200 0 1 3 0 12345678
R c 00000200 0 1 f 0 c2c25678
# back-pressure on B and R
W d 00010300 1 1 f 4 5a5a0001 5a5a0002
R e 00010300 1 1 f 3 5a5a0001 5a5a0002
R f 00010100 3 1 f 5 a0000001 a0000002 a0000003 a0000004
W 2 00000400 3 1 f 3 00000011 00000022 00000033 00000044
R 3 00000400 3 1 f 6 00000011 00000022 00000033 00000044

//--- tb_soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_top;

  localparam int TIMEOUT = 200;
  localparam int AWREADY = 0;
  localparam int WREADY  = 1;
  localparam int BVALID  = 2;
  localparam int ARREADY = 3;
  localparam int RVALID  = 4;

  logic        clk;
  logic        rst_n;
  logic [3:0]  awid;
  logic [31:0] awaddr;
  logic [3:0]  awlen;
  logic [1:0]  awburst;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic [3:0]  bid;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  arid;
  logic [31:0] araddr;
  logic [3:0]  arlen;
  logic [1:0]  arburst;
  logic        arvalid;
  logic        arready;
  logic [3:0]  rid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rlast;
  logic        rvalid;
  logic        rready;

  int errors;
  int fails;
  int txns;
  int fd;
  int code;
  string op;
  string rest;
  logic [31:0] f_id, f_addr, f_len, f_burst, f_strb, f_stall;
  logic [31:0] words [16];

  tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

  soc_top #(.MEM_WORDS(1024)) uut (.*);

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic logic sig_now(input int which);
    case (which)
      AWREADY: return awready;
      WREADY:  return wready;
      BVALID:  return bvalid;
      ARREADY: return arready;
      default: return rvalid;
    endcase
  endfunction

  // Returns at the falling edge where the signal is seen high
  task automatic wait_for(input int which, input string name);
    int cycles;
    cycles = 0;
    if (fails != 0) return;
    @(negedge clk);
    while (sig_now(which) !== 1'b1 && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    if (sig_now(which) !== 1'b1) begin
      fails++;
      $display("Timeout: %s never went high", name);
    end
  endtask

  task automatic write_burst();
    int n;
    n = int'(f_len[3:0]) + 1;
    awid    = f_id[3:0];
    awaddr  = f_addr;
    awlen   = f_len[3:0];
    awburst = f_burst[1:0];
    awvalid = 1'b1;
    wait_for(AWREADY, "awready");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    for (int i = 0; i < n; i++) begin
      wdata  = words[i[3:0]];
      wstrb  = f_strb[3:0];
      wlast  = (i == n - 1);
      wvalid = 1'b1;
      wait_for(WREADY, "wready");
      @(posedge clk);
      #1;
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    bready = (f_stall == 0);
    wait_for(BVALID, "bvalid");
    check("bid", 32'(bid), f_id);
    check("bresp", 32'(bresp), 0);
    if (f_stall != 0) begin
      for (int i = 0; i < int'(f_stall); i++) begin
        @(negedge clk);
        check("bvalid", 32'(bvalid), 1);
        check("bid", 32'(bid), f_id);
      end
      @(posedge clk);
      #1;
      bready = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_burst();
    int n;
    int hold_beat;
    logic [31:0] held;
    n = int'(f_len[3:0]) + 1;
    hold_beat = n / 2;
    arid    = f_id[3:0];
    araddr  = f_addr;
    arlen   = f_len[3:0];
    arburst = f_burst[1:0];
    arvalid = 1'b1;
    wait_for(ARREADY, "arready");
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    for (int b = 0; b < n; b++) begin
      rready = !(b == hold_beat && f_stall != 0);
      wait_for(RVALID, "rvalid");
      if (!rready) begin
        held = rdata;
        for (int i = 0; i < int'(f_stall); i++) begin
          @(negedge clk);
          check("rvalid", 32'(rvalid), 1);
          check("rdata", rdata, held);
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(negedge clk);
      end
      check("rdata", rdata, words[b[3:0]]);
      check("rid", 32'(rid), f_id);
      check("rresp", 32'(rresp), 0);
      check("rlast", 32'(rlast), (b == n - 1) ? 1 : 0);
      @(posedge clk);
      #1;
      rready = 1'b0;
    end
    // No extra beat after the last one, watched past the read latency
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check("rvalid", 32'(rvalid), 0);
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    int cycles;
    errors  = 0;
    fails   = 0;
    txns    = 0;
    cycles  = 0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awburst = 2'b01;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arburst = 2'b01;
    arvalid = 1'b0;
    rready  = 1'b0;

    while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    @(negedge clk);
    check("awready", 32'(awready), 1);
    check("arready", 32'(arready), 1);
    check("wready", 32'(wready), 0);
    check("bvalid", 32'(bvalid), 0);
    check("rvalid", 32'(rvalid), 0);
    @(posedge clk);
    #1;

    fd = $fopen("soc_tests.txt", "r");
    if (fd == 0) begin
      fails++;
      $display("Could not open soc_tests.txt");
    end
    while (fd != 0 && fails == 0 && !$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) break;
      if (op.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h %h", f_id, f_addr, f_len, f_burst, f_strb, f_stall);
        for (int i = 0; i <= int'(f_len[3:0]); i++) begin
          code = $fscanf(fd, "%h", words[i[3:0]]);
        end
        if (op == "W") begin
          write_burst();
        end else if (op == "R") begin
          read_burst();
        end else begin
          fails++;
          $display("Unknown operation %s in soc_tests.txt", op);
        end
        txns++;
      end
    end
    if (fd != 0) $fclose(fd);
    if (txns == 0 && fails == 0) begin
      fails++;
      $display("No transactions found in soc_tests.txt");
    end

    $display("Done: %0d transactions, %0d mismatches, %0d other failures, %0d assertion failures",
             txns, errors, fails, uut.u_asserts.fail_count);
    if (errors == 0 && fails == 0 && uut.u_asserts.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- soc_top_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top_asserts (
  input logic        clk,
  input logic        rst_n,
  input logic        awvalid,
  input logic        awready,
  input logic [31:0] awaddr,
  input logic        arvalid,
  input logic        arready,
  input logic [31:0] araddr,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic        rlast
);

  int fail_count = 0;

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      fail_count++;
      $error("awvalid or awaddr changed before awready");
    end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      fail_count++;
      $error("arvalid or araddr changed before arready");
    end

  // Slave side must keep the beat while the master stalls
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before rready");
    end

  rlast_valid: assert property (@(posedge clk) disable iff (!rst_n)
    rlast |-> rvalid)
    else begin
      fail_count++;
      $error("rlast high without rvalid");
    end

endmodule

bind soc_top soc_top_asserts u_asserts (
  .clk(clk), .rst_n(rst_n),
  .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
  .arvalid(arvalid), .arready(arready), .araddr(araddr),
  .rvalid(rvalid), .rready(rready), .rdata(rdata), .rlast(rlast)
);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held over the first 3 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [axi_pkg::ID_BITS-1:0]   awid,
  input  logic [axi_pkg::ADDR_BITS-1:0] awaddr,
  input  logic [axi_pkg::LEN_BITS-1:0]  awlen,
  input  logic [1:0]                    awburst,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axi_pkg::DATA_BITS-1:0] wdata,
  input  logic [axi_pkg::STRB_BITS-1:0] wstrb,
  input  logic                          wlast,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [axi_pkg::ID_BITS-1:0]   bid,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [axi_pkg::ID_BITS-1:0]   arid,
  input  logic [axi_pkg::ADDR_BITS-1:0] araddr,
  input  logic [axi_pkg::LEN_BITS-1:0]  arlen,
  input  logic [1:0]                    arburst,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [axi_pkg::ID_BITS-1:0]   rid,
  output logic [axi_pkg::DATA_BITS-1:0] rdata,
  output logic [1:0]                    rresp,
  output logic                          rlast,
  output logic                          rvalid,
  input  logic                          rready
);

  localparam int AW = $clog2(MEM_WORDS);

  axi_if mst_bus ();
  axi_if im_bus ();
  axi_if dm_bus ();

  logic im_cnt_load, im_cnt_step, im_cnt_fixed, im_cnt_last;
  logic dm_cnt_load, dm_cnt_step, dm_cnt_fixed, dm_cnt_last;
  logic [AW-1:0] im_cnt_start, im_cnt_addr, im_mem_addr;
  logic [AW-1:0] dm_cnt_start, dm_cnt_addr, dm_mem_addr;
  logic [axi_pkg::LEN_BITS-1:0] im_cnt_len, dm_cnt_len;
  logic im_mem_en, im_mem_we, dm_mem_en, dm_mem_we;
  logic [axi_pkg::STRB_BITS-1:0] im_mem_strb, dm_mem_strb;
  logic [axi_pkg::DATA_BITS-1:0] im_mem_wdata, im_mem_rdata;
  logic [axi_pkg::DATA_BITS-1:0] dm_mem_wdata, dm_mem_rdata;

  // External master port onto the router bus
  assign mst_bus.awid    = awid;
  assign mst_bus.awaddr  = awaddr;
  assign mst_bus.awlen   = awlen;
  assign mst_bus.awburst = axi_pkg::burst_e'(awburst);
  assign mst_bus.awvalid = awvalid;
  assign awready         = mst_bus.awready;
  assign mst_bus.wdata   = wdata;
  assign mst_bus.wstrb   = wstrb;
  assign mst_bus.wlast   = wlast;
  assign mst_bus.wvalid  = wvalid;
  assign wready          = mst_bus.wready;
  assign bid             = mst_bus.bid;
  assign bresp           = mst_bus.bresp;
  assign bvalid          = mst_bus.bvalid;
  assign mst_bus.bready  = bready;
  assign mst_bus.arid    = arid;
  assign mst_bus.araddr  = araddr;
  assign mst_bus.arlen   = arlen;
  assign mst_bus.arburst = axi_pkg::burst_e'(arburst);
  assign mst_bus.arvalid = arvalid;
  assign arready         = mst_bus.arready;
  assign rid             = mst_bus.rid;
  assign rdata           = mst_bus.rdata;
  assign rresp           = mst_bus.rresp;
  assign rlast           = mst_bus.rlast;
  assign rvalid          = mst_bus.rvalid;
  assign mst_bus.rready  = rready;

  axi_router u_router (
    .clk, .rst_n,
    .mst(mst_bus), .im(im_bus), .dm(dm_bus)
  );

  // Instruction memory
  slave_fsm #(.MEM_WORDS(MEM_WORDS)) im_fsm (
    .clk, .rst_n, .bus(im_bus),
    .cnt_load(im_cnt_load), .cnt_step(im_cnt_step), .cnt_fixed(im_cnt_fixed),
    .cnt_start(im_cnt_start), .cnt_len(im_cnt_len),
    .cnt_addr(im_cnt_addr), .cnt_last(im_cnt_last),
    .mem_en(im_mem_en), .mem_we(im_mem_we), .mem_strb(im_mem_strb),
    .mem_addr(im_mem_addr), .mem_wdata(im_mem_wdata), .mem_rdata(im_mem_rdata)
  );

  burst_counter #(.MEM_WORDS(MEM_WORDS)) im_counter (
    .clk, .rst_n,
    .load(im_cnt_load), .step(im_cnt_step), .fixed(im_cnt_fixed),
    .start(im_cnt_start), .len(im_cnt_len),
    .addr(im_cnt_addr), .last(im_cnt_last)
  );

  sram_array #(.MEM_WORDS(MEM_WORDS)) im_sram (
    .clk, .en(im_mem_en), .we(im_mem_we), .strb(im_mem_strb),
    .addr(im_mem_addr), .wdata(im_mem_wdata), .rdata(im_mem_rdata)
  );

  // Data memory
  slave_fsm #(.MEM_WORDS(MEM_WORDS)) dm_fsm (
    .clk, .rst_n, .bus(dm_bus),
    .cnt_load(dm_cnt_load), .cnt_step(dm_cnt_step), .cnt_fixed(dm_cnt_fixed),
    .cnt_start(dm_cnt_start), .cnt_len(dm_cnt_len),
    .cnt_addr(dm_cnt_addr), .cnt_last(dm_cnt_last),
    .mem_en(dm_mem_en), .mem_we(dm_mem_we), .mem_strb(dm_mem_strb),
    .mem_addr(dm_mem_addr), .mem_wdata(dm_mem_wdata), .mem_rdata(dm_mem_rdata)
  );

  burst_counter #(.MEM_WORDS(MEM_WORDS)) dm_counter (
    .clk, .rst_n,
    .load(dm_cnt_load), .step(dm_cnt_step), .fixed(dm_cnt_fixed),
    .start(dm_cnt_start), .len(dm_cnt_len),
    .addr(dm_cnt_addr), .last(dm_cnt_last)
  );

  sram_array #(.MEM_WORDS(MEM_WORDS)) dm_sram (
    .clk, .en(dm_mem_en), .we(dm_mem_we), .strb(dm_mem_strb),
    .addr(dm_mem_addr), .wdata(dm_mem_wdata), .rdata(dm_mem_rdata)
  );

endmodule

`default_nettype wire

//--- slave_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module slave_fsm #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                          clk,
  input  logic                          rst_n,
  axi_if.slave                          bus,
  output logic                          cnt_load,
  output logic                          cnt_step,
  output logic                          cnt_fixed,
  output logic [$clog2(MEM_WORDS)-1:0]  cnt_start,
  output logic [axi_pkg::LEN_BITS-1:0]  cnt_len,
  input  logic [$clog2(MEM_WORDS)-1:0]  cnt_addr,
  input  logic                          cnt_last,
  output logic                          mem_en,
  output logic                          mem_we,
  output logic [axi_pkg::STRB_BITS-1:0] mem_strb,
  output logic [$clog2(MEM_WORDS)-1:0]  mem_addr,
  output logic [axi_pkg::DATA_BITS-1:0] mem_wdata,
  input  logic [axi_pkg::DATA_BITS-1:0] mem_rdata
);

  localparam int AW  = $clog2(MEM_WORDS);
  localparam int OFS = $clog2(axi_pkg::STRB_BITS);

  mem_pkg::state_e state;
  mem_pkg::state_e state_nxt;
  logic [axi_pkg::ID_BITS-1:0]   id_q;
  logic [axi_pkg::DATA_BITS-1:0] rdata_q;
  logic fixed_q;
  logic rd_issued;
  logic aw_hs;
  logic ar_hs;
  logic w_hs;
  logic r_hs;
  logic b_hs;

  // Writes win over reads in IDLE
  assign bus.awready = state == mem_pkg::IDLE;
  assign bus.arready = state == mem_pkg::IDLE && !bus.awvalid;
  assign bus.wready  = state == mem_pkg::WRITE_BEAT;
  assign bus.bvalid  = state == mem_pkg::WRITE_RESP;
  assign bus.rvalid  = state == mem_pkg::READ_BEAT;
  assign bus.rlast   = state == mem_pkg::READ_BEAT && cnt_last;
  assign bus.bid     = id_q;
  assign bus.rid     = id_q;
  assign bus.bresp   = axi_pkg::OKAY;
  assign bus.rresp   = axi_pkg::OKAY;
  assign bus.rdata   = rdata_q;

  assign aw_hs = bus.awvalid && bus.awready;
  assign ar_hs = bus.arvalid && bus.arready;
  assign w_hs  = bus.wvalid && bus.wready;
  assign r_hs  = bus.rvalid && bus.rready;
  assign b_hs  = bus.bvalid && bus.bready;

  assign cnt_load  = aw_hs || ar_hs;
  assign cnt_start = aw_hs ? bus.awaddr[OFS +: AW] : bus.araddr[OFS +: AW];
  assign cnt_len   = aw_hs ? bus.awlen : bus.arlen;
  assign cnt_step  = w_hs || r_hs;
  assign cnt_fixed = fixed_q;

  // One array read per beat, captured a cycle later
  assign mem_en    = w_hs || (state == mem_pkg::READ_WAIT && !rd_issued);
  assign mem_we    = w_hs;
  assign mem_strb  = bus.wstrb;
  assign mem_wdata = bus.wdata;
  assign mem_addr  = cnt_addr;

  always_comb begin
    state_nxt = state;
    case (state)
      mem_pkg::IDLE: begin
        if (aw_hs) state_nxt = mem_pkg::WRITE_BEAT;
        else if (ar_hs) state_nxt = mem_pkg::READ_WAIT;
      end
      mem_pkg::READ_WAIT: begin
        if (rd_issued) state_nxt = mem_pkg::READ_BEAT;
      end
      mem_pkg::READ_BEAT: begin
        if (r_hs) state_nxt = cnt_last ? mem_pkg::IDLE : mem_pkg::READ_WAIT;
      end
      mem_pkg::WRITE_BEAT: begin
        if (w_hs && cnt_last) state_nxt = mem_pkg::WRITE_RESP;
      end
      mem_pkg::WRITE_RESP: begin
        if (b_hs) state_nxt = mem_pkg::IDLE;
      end
      default: state_nxt = mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= mem_pkg::IDLE;
      rd_issued <= 1'b0;
      fixed_q   <= 1'b0;
    end else begin
      state     <= state_nxt;
      rd_issued <= state == mem_pkg::READ_WAIT && !rd_issued;
      if (aw_hs) fixed_q <= bus.awburst == axi_pkg::FIXED;
      else if (ar_hs) fixed_q <= bus.arburst == axi_pkg::FIXED;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) id_q <= bus.awid;
    else if (ar_hs) id_q <= bus.arid;
    if (state == mem_pkg::READ_WAIT && rd_issued) rdata_q <= mem_rdata;
  end

endmodule

`default_nettype wire

//--- sram_array.sv
`timescale 1ns/1ns
`default_nettype none

module sram_array #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                          clk,
  input  logic                          en,
  input  logic                          we,
  input  logic [axi_pkg::STRB_BITS-1:0] strb,
  input  logic [$clog2(MEM_WORDS)-1:0]  addr,
  input  logic [axi_pkg::DATA_BITS-1:0] wdata,
  output logic [axi_pkg::DATA_BITS-1:0] rdata
);

  logic [axi_pkg::DATA_BITS-1:0] mem [MEM_WORDS];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int i = 0; i < axi_pkg::STRB_BITS; i++) begin
          if (strb[i]) mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- burst_counter.sv
`timescale 1ns/1ns
`default_nettype none

module burst_counter #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load,
  input  logic                         step,
  input  logic                         fixed,
  input  logic [$clog2(MEM_WORDS)-1:0] start,
  input  logic [axi_pkg::LEN_BITS-1:0] len,
  output logic [$clog2(MEM_WORDS)-1:0] addr,
  output logic                         last
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam logic [AW-1:0] TOP_WORD = AW'(MEM_WORDS - 1);

  // Beats still to come after the current one
  logic [axi_pkg::LEN_BITS-1:0] left;

  assign last = left == '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr <= '0;
      left <= '0;
    end else if (load) begin
      addr <= start;
      left <= len;
    end else if (step) begin
      if (!last) left <= left - 1'b1;
      if (!fixed) addr <= (addr == TOP_WORD) ? '0 : addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- axi_router.sv
`timescale 1ns/1ns
`default_nettype none

module axi_router (
  input  logic  clk,
  input  logic  rst_n,
  axi_if.slave  mst,
  axi_if.master im,
  axi_if.master dm
);

  logic ar_sel;
  logic aw_sel;
  logic rd_busy;
  logic rd_dm;
  logic wr_busy;
  logic wr_dm;

  assign ar_sel = mst.araddr[mem_pkg::SEL_BIT];
  assign aw_sel = mst.awaddr[mem_pkg::SEL_BIT];

  // Write address goes to both, valid only to the selected slave
  assign im.awid    = mst.awid;
  assign im.awaddr  = mst.awaddr;
  assign im.awlen   = mst.awlen;
  assign im.awburst = mst.awburst;
  assign dm.awid    = mst.awid;
  assign dm.awaddr  = mst.awaddr;
  assign dm.awlen   = mst.awlen;
  assign dm.awburst = mst.awburst;
  assign im.awvalid = mst.awvalid && !wr_busy && !aw_sel;
  assign dm.awvalid = mst.awvalid && !wr_busy && aw_sel;
  assign mst.awready = !wr_busy && (aw_sel ? dm.awready : im.awready);

  // Write data follows the recorded write owner
  assign im.wdata  = mst.wdata;
  assign im.wstrb  = mst.wstrb;
  assign im.wlast  = mst.wlast;
  assign dm.wdata  = mst.wdata;
  assign dm.wstrb  = mst.wstrb;
  assign dm.wlast  = mst.wlast;
  assign im.wvalid = mst.wvalid && wr_busy && !wr_dm;
  assign dm.wvalid = mst.wvalid && wr_busy && wr_dm;
  assign mst.wready = wr_busy && (wr_dm ? dm.wready : im.wready);

  assign mst.bid    = wr_dm ? dm.bid : im.bid;
  assign mst.bresp  = wr_dm ? dm.bresp : im.bresp;
  assign mst.bvalid = wr_busy && (wr_dm ? dm.bvalid : im.bvalid);
  assign im.bready  = mst.bready && wr_busy && !wr_dm;
  assign dm.bready  = mst.bready && wr_busy && wr_dm;

  assign im.arid    = mst.arid;
  assign im.araddr  = mst.araddr;
  assign im.arlen   = mst.arlen;
  assign im.arburst = mst.arburst;
  assign dm.arid    = mst.arid;
  assign dm.araddr  = mst.araddr;
  assign dm.arlen   = mst.arlen;
  assign dm.arburst = mst.arburst;
  assign im.arvalid = mst.arvalid && !rd_busy && !ar_sel;
  assign dm.arvalid = mst.arvalid && !rd_busy && ar_sel;
  assign mst.arready = !rd_busy && (ar_sel ? dm.arready : im.arready);

  // Read data back from the recorded read owner
  assign mst.rid    = rd_dm ? dm.rid : im.rid;
  assign mst.rdata  = rd_dm ? dm.rdata : im.rdata;
  assign mst.rresp  = rd_dm ? dm.rresp : im.rresp;
  assign mst.rlast  = rd_busy && (rd_dm ? dm.rlast : im.rlast);
  assign mst.rvalid = rd_busy && (rd_dm ? dm.rvalid : im.rvalid);
  assign im.rready  = mst.rready && rd_busy && !rd_dm;
  assign dm.rready  = mst.rready && rd_busy && rd_dm;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_busy <= 1'b0;
      rd_dm   <= 1'b0;
      wr_busy <= 1'b0;
      wr_dm   <= 1'b0;
    end else begin
      if (mst.arvalid && mst.arready) begin
        rd_busy <= 1'b1;
        rd_dm   <= ar_sel;
      end else if (mst.rvalid && mst.rready && mst.rlast) begin
        rd_busy <= 1'b0;
      end
      if (mst.awvalid && mst.awready) begin
        wr_busy <= 1'b1;
        wr_dm   <= aw_sel;
      end else if (mst.bvalid && mst.bready) begin
        wr_busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- axi_if.sv
`timescale 1ns/1ns
`default_nettype none

interface axi_if;

  logic [axi_pkg::ID_BITS-1:0]   awid;
  logic [axi_pkg::ADDR_BITS-1:0] awaddr;
  logic [axi_pkg::LEN_BITS-1:0]  awlen;
  axi_pkg::burst_e               awburst;
  logic                          awvalid;
  logic                          awready;

  logic [axi_pkg::DATA_BITS-1:0] wdata;
  logic [axi_pkg::STRB_BITS-1:0] wstrb;
  logic                          wlast;
  logic                          wvalid;
  logic                          wready;

  logic [axi_pkg::ID_BITS-1:0]   bid;
  axi_pkg::resp_e                bresp;
  logic                          bvalid;
  logic                          bready;

  logic [axi_pkg::ID_BITS-1:0]   arid;
  logic [axi_pkg::ADDR_BITS-1:0] araddr;
  logic [axi_pkg::LEN_BITS-1:0]  arlen;
  axi_pkg::burst_e               arburst;
  logic                          arvalid;
  logic                          arready;

  logic [axi_pkg::ID_BITS-1:0]   rid;
  logic [axi_pkg::DATA_BITS-1:0] rdata;
  axi_pkg::resp_e                rresp;
  logic                          rlast;
  logic                          rvalid;
  logic                          rready;

  modport master (
    output awid, awaddr, awlen, awburst, awvalid, input awready,
    output wdata, wstrb, wlast, wvalid, input wready,
    input bid, bresp, bvalid, output bready,
    output arid, araddr, arlen, arburst, arvalid, input arready,
    input rid, rdata, rresp, rlast, rvalid, output rready
  );

  modport slave (
    input awid, awaddr, awlen, awburst, awvalid, output awready,
    input wdata, wstrb, wlast, wvalid, output wready,
    output bid, bresp, bvalid, input bready,
    input arid, araddr, arlen, arburst, arvalid, output arready,
    output rid, rdata, rresp, rlast, rvalid, input rready
  );

endinterface

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Set selects DM, clear selects IM
  localparam int SEL_BIT = 16;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    READ_WAIT  = 3'd1,
    READ_BEAT  = 3'd2,
    WRITE_BEAT = 3'd3,
    WRITE_RESP = 3'd4
  } state_e;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

  localparam int ID_BITS   = 4;
  localparam int ADDR_BITS = 32;
  localparam int DATA_BITS = 32;
  localparam int STRB_BITS = 4;
  // 1 to 16 beats
  localparam int LEN_BITS  = 4;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

endpackage

`default_nettype wire
